// File: Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing
TOP ?= decode_ctrl_tb
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	-./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^TEST PASS$$" $(LOG); then echo "result: pass"; \
	else echo "result: fail"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: project.f
+incdir+src
+incdir+test
src/decode_pkg.sv
src/insn_latch_pipe.sv
src/if_predecode.sv
src/id_operand_gen.sv
src/ex_op_decode.sv
src/operand_forward.sv
src/decode_ctrl.sv
test/decode_ctrl_tb.sv

// File: src/decode_ctrl.sv
module decode_ctrl (
	input logic clk,
	input logic reset,
	input logic id_freeze,
	input logic ex_freeze,
	input logic wb_freeze,
	input logic except_flushpipe,
	input logic extend_flush,
	input logic pc_we,
	input logic du_flush_pipe,
	input logic abort_mvspr,
	input decode_pkg::insn_t if_insn,
	input decode_pkg::word_t id_pc,
	input logic wbforw_valid,
	input logic du_hwbkpt,
	output logic flushpipe,
	output decode_pkg::insn_t id_insn,
	output decode_pkg::insn_t ex_insn,
	output decode_pkg::insn_t wb_insn,
	output decode_pkg::reg_addr_t rf_addra,
	output decode_pkg::reg_addr_t rf_addrb,
	output logic rf_rda,
	output logic rf_rdb,
	output decode_pkg::branch_op_e id_branch_op,
	output decode_pkg::ex_ctrl_t ex_ctrl,
	output logic ex_spr_read,
	output logic ex_spr_write,
	output logic rfe,
	output decode_pkg::fwd_sel_e sel_a,
	output decode_pkg::fwd_sel_e sel_b,
	output decode_pkg::word_t id_simm,
	output decode_pkg::word_t ex_simm,
	output decode_pkg::target_t id_branch_target,
	output decode_pkg::target_t ex_branch_target,
	output decode_pkg::lsu_op_t id_lsu_op,
	output logic except_illegal,
	output logic sig_syscall,
	output logic sig_trap
);

	// EX nop request from the latch pipe
	logic ex_bubble;
	// registered IF predecode, used by the b operand select
	logic sel_imm;

	////////////////////////////////////////////////////////////
	// stage registers and flush
	////////////////////////////////////////////////////////////

	insn_latch_pipe i_insn_latch_pipe (
		.clk(clk),
		.reset(reset),
		.id_freeze(id_freeze),
		.ex_freeze(ex_freeze),
		.wb_freeze(wb_freeze),
		.except_flushpipe(except_flushpipe),
		.extend_flush(extend_flush),
		.pc_we(pc_we),
		.du_flush_pipe(du_flush_pipe),
		.if_insn(if_insn),
		.id_insn(id_insn),
		.ex_insn(ex_insn),
		.wb_insn(wb_insn),
		.flushpipe(flushpipe),
		.ex_bubble(ex_bubble)
	);

	if_predecode i_if_predecode (
		.clk(clk),
		.reset(reset),
		.id_freeze(id_freeze),
		.flushpipe(flushpipe),
		.if_insn(if_insn),
		.id_branch_op(id_branch_op),
		.sel_imm(sel_imm),
		.rf_addra(rf_addra),
		.rf_addrb(rf_addrb),
		.rf_rda(rf_rda),
		.rf_rdb(rf_rdb)
	);

	////////////////////////////////////////////////////////////
	// ID operands and EX control
	////////////////////////////////////////////////////////////

	id_operand_gen i_id_operand_gen (
		.clk(clk),
		.reset(reset),
		.ex_freeze(ex_freeze),
		.id_insn(id_insn),
		.id_pc(id_pc),
		.id_simm(id_simm),
		.ex_simm(ex_simm),
		.id_branch_target(id_branch_target),
		.ex_branch_target(ex_branch_target),
		.id_lsu_op(id_lsu_op)
	);

	ex_op_decode i_ex_op_decode (
		.clk(clk),
		.reset(reset),
		.ex_freeze(ex_freeze),
		.ex_bubble(ex_bubble),
		.abort_mvspr(abort_mvspr),
		.du_hwbkpt(du_hwbkpt),
		.id_insn(id_insn),
		.id_branch_op(id_branch_op),
		.ex_ctrl(ex_ctrl),
		.ex_spr_read(ex_spr_read),
		.ex_spr_write(ex_spr_write),
		.rfe(rfe),
		.except_illegal(except_illegal),
		.sig_syscall(sig_syscall),
		.sig_trap(sig_trap)
	);

	// forwarding compares against the EX destination
	operand_forward i_operand_forward (
		.clk(clk),
		.reset(reset),
		.wb_freeze(wb_freeze),
		.wbforw_valid(wbforw_valid),
		.sel_imm(sel_imm),
		.id_insn(id_insn),
		.rf_addrw(ex_ctrl.rf_addrw),
		.rfwb_we(ex_ctrl.rfwb_op.we),
		.sel_a(sel_a),
		.sel_b(sel_b)
	);

endmodule

// File: src/decode_macros.svh
`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

////////////////////////////////////////////////////////////
// major opcodes, architecture numbering
////////////////////////////////////////////////////////////
`define OPCODE_J 6'h00
`define OPCODE_JAL 6'h01
`define OPCODE_BNF 6'h03
`define OPCODE_BF 6'h04
`define OPCODE_NOP 6'h05
`define OPCODE_MOVHI 6'h06
`define OPCODE_XSYNC 6'h08
`define OPCODE_RFE 6'h09
`define OPCODE_JR 6'h11
`define OPCODE_JALR 6'h12
`define OPCODE_LWZ 6'h21
`define OPCODE_LWS 6'h22
`define OPCODE_LBZ 6'h23
`define OPCODE_LBS 6'h24
`define OPCODE_LHZ 6'h25
`define OPCODE_LHS 6'h26
`define OPCODE_ADDI 6'h27
`define OPCODE_ADDIC 6'h28
`define OPCODE_ANDI 6'h29
`define OPCODE_ORI 6'h2a
`define OPCODE_XORI 6'h2b
`define OPCODE_MFSPR 6'h2d
`define OPCODE_SFXXI 6'h2f
`define OPCODE_MTSPR 6'h30
`define OPCODE_SW 6'h35
`define OPCODE_SB 6'h36
`define OPCODE_SH 6'h37
`define OPCODE_ALU 6'h38
`define OPCODE_SFXX 6'h39

// instruction fields
`define OPCODE_POS 31:26
`define RD_POS 25:21
`define RA_POS 20:16
`define RB_POS 15:11
`define COMPOP_POS 24:21
`define ALUOP2_POS 9:6
`define ALUOP_POS 4:0
// shift/rotate sub-op, 3 means rotate right
`define SHROTOP_POS 7:6
`define SHROTOP_ROR 2'd3

// nop with bit 16 set, marks an injected bubble
`define NOP_INSN 32'h1541_0000
// r9 takes the return address of jal/jalr
`define LINK_REG 5'd9

////////////////////////////////////////////////////////////
// alu function codes
////////////////////////////////////////////////////////////
`define ALUOP_ADD 5'd0
`define ALUOP_ADDC 5'd1
`define ALUOP_SUB 5'd2
`define ALUOP_AND 5'd3
`define ALUOP_OR 5'd4
`define ALUOP_XOR 5'd5
`define ALUOP_MUL 5'd6
`define ALUOP_SHROT 5'd8
`define ALUOP_DIV 5'd9
`define ALUOP_DIVU 5'd10
`define ALUOP_MULU 5'd11
`define ALUOP_EXTHB 5'd12
`define ALUOP_EXTW 5'd13
`define ALUOP_FFL1 5'd15
// internal codes, above any 4-bit alu field
`define ALUOP_MOVHI 5'd16
`define ALUOP_COMP 5'd17
`define ALUOP_NOP 5'd18

// load/store unit ops
`define LSUOP_NOP 4'b0000
`define LSUOP_LBZ 4'b0010
`define LSUOP_LBS 4'b0011
`define LSUOP_LHZ 4'b0100
`define LSUOP_LHS 4'b0101
`define LSUOP_LWZ 4'b0110
`define LSUOP_LWS 4'b0111
`define LSUOP_SB 4'b1000
`define LSUOP_SH 4'b1010
`define LSUOP_SW 4'b1100

`endif

// File: src/decode_pkg.sv
package decode_pkg;

	////////////////////////////////////////////////////////////
	// plain vectors
	////////////////////////////////////////////////////////////
	typedef logic [31:0] insn_t;
	typedef logic [5:0] opcode_t;
	typedef logic [4:0] reg_addr_t;
	typedef logic [31:0] word_t;
	// word address, pc bits 31:2
	typedef logic [29:0] target_t;
	typedef logic [4:0] alu_op_t;
	typedef logic [3:0] comp_op_t;
	typedef logic [3:0] lsu_op_t;

	// branch kind, decoded one stage early
	typedef enum logic [2:0] {
		BR_NOP,
		BR_J,
		BR_JR,
		BR_BNF,
		BR_BF,
		BR_RFE
	} branch_op_e;

	// operand source for the alu inputs
	typedef enum logic [1:0] {
		SEL_RF,
		SEL_EX_FORW,
		SEL_WB_FORW,
		SEL_IMM
	} fwd_sel_e;

	// where the writeback value comes from
	typedef enum logic [2:0] {
		RFWB_NONE,
		RFWB_ALU,
		RFWB_LR,
		RFWB_SPRS,
		RFWB_LSU
	} rfwb_src_e;

	// write enable sits in bit 0
	typedef struct packed {
		rfwb_src_e src;
		logic we;
	} rfwb_op_t;

	typedef struct packed {
		alu_op_t alu_op;
		logic [3:0] alu_op2;
		comp_op_t comp_op;
		rfwb_op_t rfwb_op;
		reg_addr_t rf_addrw;
		branch_op_e branch_op;
		logic spr_read;
		logic spr_write;
	} ex_ctrl_t;

endpackage

// File: src/ex_op_decode.sv
`include "decode_macros.svh"

module ex_op_decode (
	input logic clk,
	input logic reset,
	input logic ex_freeze,
	input logic ex_bubble,
	input logic abort_mvspr,
	input logic du_hwbkpt,
	input decode_pkg::insn_t id_insn,
	input decode_pkg::branch_op_e id_branch_op,
	output decode_pkg::ex_ctrl_t ex_ctrl,
	output logic ex_spr_read,
	output logic ex_spr_write,
	output logic rfe,
	output logic except_illegal,
	output logic sig_syscall,
	output logic sig_trap
);

	// EX state of a nop
	localparam decode_pkg::ex_ctrl_t CTRL_IDLE = '{
		alu_op: `ALUOP_NOP,
		alu_op2: 4'd0,
		comp_op: 4'd0,
		rfwb_op: '{src: decode_pkg::RFWB_NONE, we: 1'b0},
		rf_addrw: 5'd0,
		branch_op: decode_pkg::BR_NOP,
		spr_read: 1'b0,
		spr_write: 1'b0
	};

	decode_pkg::opcode_t opcode;
	decode_pkg::alu_op_t alu_func;
	decode_pkg::ex_ctrl_t ctrl_next;
	logic alu_illegal;
	logic illegal_next;
	logic syscall_next;
	logic trap_next;

	assign opcode = id_insn[`OPCODE_POS];
	assign alu_func = id_insn[`ALUOP_POS];

	// alu functions without hardware here
	assign alu_illegal = (alu_func inside {`ALUOP_MUL, `ALUOP_MULU, `ALUOP_DIV,
		`ALUOP_DIVU, `ALUOP_FFL1, `ALUOP_EXTHB, `ALUOP_EXTW}) |
		((alu_func == `ALUOP_SHROT) & (id_insn[`SHROTOP_POS] == `SHROTOP_ROR));

	// l.sys and l.trap share the xsync opcode
	assign syscall_next = (id_insn[31:23] == {`OPCODE_XSYNC, 3'b000});
	assign trap_next = (id_insn[31:23] == {`OPCODE_XSYNC, 3'b010}) | du_hwbkpt;

	////////////////////////////////////////////////////////////
	// control decode from the ID insn
	////////////////////////////////////////////////////////////

	always_comb begin
		ctrl_next = CTRL_IDLE;
		ctrl_next.alu_op2 = id_insn[`ALUOP2_POS];
		ctrl_next.comp_op = id_insn[`COMPOP_POS];
		ctrl_next.rf_addrw = id_insn[`RD_POS];
		ctrl_next.branch_op = id_branch_op;
		illegal_next = 1'b0;
		case (opcode)
			// link writes r9
			`OPCODE_JAL, `OPCODE_JALR: begin
				ctrl_next.rfwb_op = '{src: decode_pkg::RFWB_LR, we: 1'b1};
				ctrl_next.rf_addrw = `LINK_REG;
			end
			`OPCODE_MOVHI: begin
				ctrl_next.alu_op = `ALUOP_MOVHI;
				ctrl_next.rfwb_op = '{src: decode_pkg::RFWB_ALU, we: 1'b1};
			end
			`OPCODE_ADDI: begin
				ctrl_next.alu_op = `ALUOP_ADD;
				ctrl_next.rfwb_op = '{src: decode_pkg::RFWB_ALU, we: 1'b1};
			end
			`OPCODE_ADDIC: begin
				ctrl_next.alu_op = `ALUOP_ADDC;
				ctrl_next.rfwb_op = '{src: decode_pkg::RFWB_ALU, we: 1'b1};
			end
			`OPCODE_ANDI: begin
				ctrl_next.alu_op = `ALUOP_AND;
				ctrl_next.rfwb_op = '{src: decode_pkg::RFWB_ALU, we: 1'b1};
			end
			`OPCODE_ORI: begin
				ctrl_next.alu_op = `ALUOP_OR;
				ctrl_next.rfwb_op = '{src: decode_pkg::RFWB_ALU, we: 1'b1};
			end
			`OPCODE_XORI: begin
				ctrl_next.alu_op = `ALUOP_XOR;
				ctrl_next.rfwb_op = '{src: decode_pkg::RFWB_ALU, we: 1'b1};
			end
			// register-register alu, function in the low bits
			`OPCODE_ALU: begin
				ctrl_next.alu_op = {1'b0, id_insn[3:0]};
				ctrl_next.rfwb_op = '{src: decode_pkg::RFWB_ALU, we: 1'b1};
				illegal_next = alu_illegal;
			end
			`OPCODE_SFXX, `OPCODE_SFXXI:
				ctrl_next.alu_op = `ALUOP_COMP;
			`OPCODE_MFSPR: begin
				ctrl_next.rfwb_op = '{src: decode_pkg::RFWB_SPRS, we: 1'b1};
				ctrl_next.spr_read = 1'b1;
			end
			`OPCODE_MTSPR:
				ctrl_next.spr_write = 1'b1;
			`OPCODE_LWZ, `OPCODE_LWS, `OPCODE_LBZ, `OPCODE_LBS,
			`OPCODE_LHZ, `OPCODE_LHS:
				ctrl_next.rfwb_op = '{src: decode_pkg::RFWB_LSU, we: 1'b1};
			// legal, no alu or writeback work
			`OPCODE_J, `OPCODE_JR, `OPCODE_BNF, `OPCODE_BF, `OPCODE_RFE,
			`OPCODE_XSYNC, `OPCODE_NOP, `OPCODE_SW, `OPCODE_SB, `OPCODE_SH:
				illegal_next = 1'b0;
			// mul, div, rotate, fpu, mac, cust5 and the rest
			default:
				illegal_next = 1'b1;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset || ex_bubble) begin
			ex_ctrl <= CTRL_IDLE;
			except_illegal <= 1'b0;
			sig_syscall <= 1'b0;
			sig_trap <= 1'b0;
		end else if (!ex_freeze) begin
			ex_ctrl <= ctrl_next;
			except_illegal <= illegal_next;
			sig_syscall <= syscall_next;
			sig_trap <= trap_next;
		end
	end

	// aborted mfspr/mtspr must not reach the spr bus
	assign ex_spr_read = ex_ctrl.spr_read & !abort_mvspr;
	assign ex_spr_write = ex_ctrl.spr_write & !abort_mvspr;

	assign rfe = (id_branch_op == decode_pkg::BR_RFE) |
		(ex_ctrl.branch_op == decode_pkg::BR_RFE);

endmodule

// File: src/id_operand_gen.sv
`include "decode_macros.svh"

module id_operand_gen (
	input logic clk,
	input logic reset,
	input logic ex_freeze,
	input decode_pkg::insn_t id_insn,
	input decode_pkg::word_t id_pc,
	output decode_pkg::word_t id_simm,
	output decode_pkg::word_t ex_simm,
	output decode_pkg::target_t id_branch_target,
	output decode_pkg::target_t ex_branch_target,
	output decode_pkg::lsu_op_t id_lsu_op
);

	decode_pkg::opcode_t opcode;

	assign opcode = id_insn[`OPCODE_POS];

	////////////////////////////////////////////////////////////
	// immediate extension
	////////////////////////////////////////////////////////////

	always_comb begin
		case (opcode)
			// signed 16-bit immediate
			`OPCODE_ADDI, `OPCODE_ADDIC, `OPCODE_XORI, `OPCODE_SFXXI,
			`OPCODE_LWZ, `OPCODE_LWS, `OPCODE_LBZ, `OPCODE_LBS,
			`OPCODE_LHZ, `OPCODE_LHS:
				id_simm = {{16{id_insn[15]}}, id_insn[15:0]};
			// spr number split around rb
			`OPCODE_MTSPR:
				id_simm = {16'b0, id_insn[25:21], id_insn[10:0]};
			// store offset, same split, signed
			`OPCODE_SW, `OPCODE_SB, `OPCODE_SH:
				id_simm = {{16{id_insn[25]}}, id_insn[25:21], id_insn[10:0]};
			default:
				id_simm = {16'b0, id_insn[15:0]};
		endcase
	end

	// 26-bit word offset relative to the ID pc
	assign id_branch_target = {{4{id_insn[25]}}, id_insn[25:0]} + id_pc[31:2];

	// load/store op for the lsu
	always_comb begin
		case (opcode)
			`OPCODE_LWZ: id_lsu_op = `LSUOP_LWZ;
			`OPCODE_LWS: id_lsu_op = `LSUOP_LWS;
			`OPCODE_LBZ: id_lsu_op = `LSUOP_LBZ;
			`OPCODE_LBS: id_lsu_op = `LSUOP_LBS;
			`OPCODE_LHZ: id_lsu_op = `LSUOP_LHZ;
			`OPCODE_LHS: id_lsu_op = `LSUOP_LHS;
			`OPCODE_SW: id_lsu_op = `LSUOP_SW;
			`OPCODE_SB: id_lsu_op = `LSUOP_SB;
			`OPCODE_SH: id_lsu_op = `LSUOP_SH;
			default: id_lsu_op = `LSUOP_NOP;
		endcase
	end

	// EX copies, a bubble leaves them as they are
	always_ff @(posedge clk) begin
		if (reset) begin
			ex_simm <= '0;
			ex_branch_target <= '0;
		end else if (!ex_freeze) begin
			ex_simm <= id_simm;
			ex_branch_target <= id_branch_target;
		end
	end

endmodule

// File: src/if_predecode.sv
`include "decode_macros.svh"

module if_predecode (
	input logic clk,
	input logic reset,
	input logic id_freeze,
	input logic flushpipe,
	input decode_pkg::insn_t if_insn,
	output decode_pkg::branch_op_e id_branch_op,
	output logic sel_imm,
	output decode_pkg::reg_addr_t rf_addra,
	output decode_pkg::reg_addr_t rf_addrb,
	output logic rf_rda,
	output logic rf_rdb
);

	decode_pkg::opcode_t opcode;
	decode_pkg::branch_op_e branch_next;
	logic imm_next;

	assign opcode = if_insn[`OPCODE_POS];

	// register file read port, straight from fetch
	assign rf_addra = if_insn[`RA_POS];
	assign rf_addrb = if_insn[`RB_POS];
	assign rf_rda = if_insn[31];
	assign rf_rdb = if_insn[30];

	////////////////////////////////////////////////////////////
	// branch kind and immediate use
	////////////////////////////////////////////////////////////

	always_comb begin
		branch_next = decode_pkg::BR_NOP;
		imm_next = 1'b1;
		case (opcode)
			`OPCODE_J, `OPCODE_JAL:
				branch_next = decode_pkg::BR_J;
			`OPCODE_JR, `OPCODE_JALR: begin
				branch_next = decode_pkg::BR_JR;
				imm_next = 1'b0;
			end
			`OPCODE_BNF:
				branch_next = decode_pkg::BR_BNF;
			`OPCODE_BF:
				branch_next = decode_pkg::BR_BF;
			`OPCODE_RFE: begin
				branch_next = decode_pkg::BR_RFE;
				imm_next = 1'b0;
			end
			// operand b from the register file
			`OPCODE_MFSPR, `OPCODE_MTSPR, `OPCODE_XSYNC, `OPCODE_SW,
			`OPCODE_SB, `OPCODE_SH, `OPCODE_ALU, `OPCODE_SFXX, `OPCODE_NOP:
				imm_next = 1'b0;
			default:
				imm_next = 1'b1;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			id_branch_op <= decode_pkg::BR_NOP;
		else if (flushpipe)
			id_branch_op <= decode_pkg::BR_NOP;
		else if (!id_freeze)
			id_branch_op <= branch_next;
	end

	// not flushed, the nop that replaces the insn ignores it
	always_ff @(posedge clk) begin
		if (reset)
			sel_imm <= 1'b0;
		else if (!id_freeze)
			sel_imm <= imm_next;
	end

endmodule

// File: src/insn_latch_pipe.sv
`include "decode_macros.svh"

module insn_latch_pipe (
	input logic clk,
	input logic reset,
	input logic id_freeze,
	input logic ex_freeze,
	input logic wb_freeze,
	input logic except_flushpipe,
	input logic extend_flush,
	input logic pc_we,
	input logic du_flush_pipe,
	input decode_pkg::insn_t if_insn,
	output decode_pkg::insn_t id_insn,
	output decode_pkg::insn_t ex_insn,
	output decode_pkg::insn_t wb_insn,
	output logic flushpipe,
	output logic ex_bubble
);

	////////////////////////////////////////////////////////////
	// flush and bubble
	////////////////////////////////////////////////////////////

	// any redirect or debug request empties IF/ID
	assign flushpipe = except_flushpipe | pc_we | extend_flush | du_flush_pipe;

	// EX moves on while ID stalls, so EX gets a nop
	assign ex_bubble = (!ex_freeze & id_freeze) | flushpipe;

	////////////////////////////////////////////////////////////
	// instruction registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset)
			id_insn <= `NOP_INSN;
		else if (flushpipe)
			id_insn <= `NOP_INSN;
		else if (!id_freeze)
			id_insn <= if_insn;
	end

	always_ff @(posedge clk) begin
		if (reset)
			ex_insn <= `NOP_INSN;
		else if (ex_bubble)
			ex_insn <= `NOP_INSN;
		else if (!ex_freeze)
			ex_insn <= id_insn;
	end

	// wb copy keeps the retired insn, flush leaves it alone
	always_ff @(posedge clk) begin
		if (reset)
			wb_insn <= `NOP_INSN;
		else if (!wb_freeze)
			wb_insn <= ex_insn;
	end

endmodule

// File: src/operand_forward.sv
`include "decode_macros.svh"

module operand_forward (
	input logic clk,
	input logic reset,
	input logic wb_freeze,
	input logic wbforw_valid,
	input logic sel_imm,
	input decode_pkg::insn_t id_insn,
	input decode_pkg::reg_addr_t rf_addrw,
	input logic rfwb_we,
	output decode_pkg::fwd_sel_e sel_a,
	output decode_pkg::fwd_sel_e sel_b
);

	decode_pkg::reg_addr_t wb_rfaddrw;

	// destination of the insn now in WB
	always_ff @(posedge clk) begin
		if (reset)
			wb_rfaddrw <= 5'd0;
		else if (!wb_freeze)
			wb_rfaddrw <= rf_addrw;
	end

	////////////////////////////////////////////////////////////
	// operand selects, EX result wins over WB
	////////////////////////////////////////////////////////////

	always_comb begin
		if ((id_insn[`RA_POS] == rf_addrw) && rfwb_we)
			sel_a = decode_pkg::SEL_EX_FORW;
		else if ((id_insn[`RA_POS] == wb_rfaddrw) && wbforw_valid)
			sel_a = decode_pkg::SEL_WB_FORW;
		else
			sel_a = decode_pkg::SEL_RF;
	end

	// immediate overrides any forward on b
	always_comb begin
		if (sel_imm)
			sel_b = decode_pkg::SEL_IMM;
		else if ((id_insn[`RB_POS] == rf_addrw) && rfwb_we)
			sel_b = decode_pkg::SEL_EX_FORW;
		else if ((id_insn[`RB_POS] == wb_rfaddrw) && wbforw_valid)
			sel_b = decode_pkg::SEL_WB_FORW;
		else
			sel_b = decode_pkg::SEL_RF;
	end

endmodule

// File: test/decode_model.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

////////////////////////////////////////////////////////////
// reference model of the decode pipe
////////////////////////////////////////////////////////////

// opcodes the decoder accepts
localparam decode_pkg::opcode_t LEGAL_OPS [29] = '{
	`OPCODE_J, `OPCODE_JAL, `OPCODE_BNF, `OPCODE_BF, `OPCODE_NOP,
	`OPCODE_MOVHI, `OPCODE_XSYNC, `OPCODE_RFE, `OPCODE_JR, `OPCODE_JALR,
	`OPCODE_LWZ, `OPCODE_LWS, `OPCODE_LBZ, `OPCODE_LBS, `OPCODE_LHZ,
	`OPCODE_LHS, `OPCODE_ADDI, `OPCODE_ADDIC, `OPCODE_ANDI, `OPCODE_ORI,
	`OPCODE_XORI, `OPCODE_MFSPR, `OPCODE_MTSPR, `OPCODE_SFXXI, `OPCODE_SFXX,
	`OPCODE_ALU, `OPCODE_SW, `OPCODE_SB, `OPCODE_SH
};

// EX controls of an empty slot
localparam decode_pkg::ex_ctrl_t IDLE_CTRL = '{
	alu_op: `ALUOP_NOP,
	alu_op2: 4'd0,
	comp_op: 4'd0,
	rfwb_op: '{src: decode_pkg::RFWB_NONE, we: 1'b0},
	rf_addrw: 5'd0,
	branch_op: decode_pkg::BR_NOP,
	spr_read: 1'b0,
	spr_write: 1'b0
};

// model pipe state
decode_pkg::insn_t ref_id_insn;
decode_pkg::insn_t ref_ex_insn;
decode_pkg::insn_t ref_wb_insn;
decode_pkg::branch_op_e ref_id_branch_op;
logic ref_sel_imm;
decode_pkg::ex_ctrl_t ref_ex_ctrl;
logic ref_illegal;
logic ref_syscall;
logic ref_trap;
decode_pkg::word_t ref_ex_simm;
decode_pkg::target_t ref_ex_target;
decode_pkg::reg_addr_t ref_wb_rfaddrw;

function automatic decode_pkg::branch_op_e branch_of(input decode_pkg::insn_t insn);
	case (insn[31:26])
		`OPCODE_J, `OPCODE_JAL: return decode_pkg::BR_J;
		`OPCODE_JR, `OPCODE_JALR: return decode_pkg::BR_JR;
		`OPCODE_BNF: return decode_pkg::BR_BNF;
		`OPCODE_BF: return decode_pkg::BR_BF;
		`OPCODE_RFE: return decode_pkg::BR_RFE;
		default: return decode_pkg::BR_NOP;
	endcase
endfunction

// operand b is an immediate unless the opcode reads rb
function automatic logic imm_used(input decode_pkg::insn_t insn);
	return !(insn[31:26] inside {`OPCODE_JALR, `OPCODE_JR, `OPCODE_RFE,
		`OPCODE_MFSPR, `OPCODE_MTSPR, `OPCODE_XSYNC, `OPCODE_SW, `OPCODE_SB,
		`OPCODE_SH, `OPCODE_ALU, `OPCODE_SFXX, `OPCODE_NOP});
endfunction

function automatic decode_pkg::word_t extend_imm(input decode_pkg::insn_t insn);
	logic [15:0] split;
	split = {insn[25:21], insn[10:0]};
	case (insn[31:26])
		`OPCODE_ADDI, `OPCODE_ADDIC, `OPCODE_XORI, `OPCODE_SFXXI, `OPCODE_LWZ,
		`OPCODE_LWS, `OPCODE_LBZ, `OPCODE_LBS, `OPCODE_LHZ, `OPCODE_LHS:
			return {{16{insn[15]}}, insn[15:0]};
		`OPCODE_MTSPR: return {16'h0000, split};
		// store offset, signed
		`OPCODE_SW, `OPCODE_SB, `OPCODE_SH: return {{16{split[15]}}, split};
		default: return {16'h0000, insn[15:0]};
	endcase
endfunction

// word offset added to the pc word address
function automatic decode_pkg::target_t branch_target_of(input decode_pkg::insn_t insn,
		input decode_pkg::word_t pc);
	decode_pkg::target_t offset;
	offset = {{4{insn[25]}}, insn[25:0]};
	return offset + pc[31:2];
endfunction

function automatic decode_pkg::lsu_op_t lsu_op_of(input decode_pkg::insn_t insn);
	case (insn[31:26])
		`OPCODE_LBZ: return `LSUOP_LBZ;
		`OPCODE_LBS: return `LSUOP_LBS;
		`OPCODE_LHZ: return `LSUOP_LHZ;
		`OPCODE_LHS: return `LSUOP_LHS;
		`OPCODE_LWZ: return `LSUOP_LWZ;
		`OPCODE_LWS: return `LSUOP_LWS;
		`OPCODE_SB: return `LSUOP_SB;
		`OPCODE_SH: return `LSUOP_SH;
		`OPCODE_SW: return `LSUOP_SW;
		default: return `LSUOP_NOP;
	endcase
endfunction

function automatic decode_pkg::ex_ctrl_t ctrl_of(input decode_pkg::insn_t insn,
		input decode_pkg::branch_op_e br);
	decode_pkg::ex_ctrl_t c;
	decode_pkg::opcode_t op;
	op = insn[31:26];
	c = IDLE_CTRL;
	c.alu_op2 = insn[9:6];
	c.comp_op = insn[24:21];
	c.rf_addrw = insn[25:21];
	c.branch_op = br;
	// writers default to the alu source
	c.rfwb_op.src = decode_pkg::RFWB_ALU;
	c.rfwb_op.we = 1'b1;
	case (op)
		`OPCODE_JAL, `OPCODE_JALR: begin
			c.rfwb_op.src = decode_pkg::RFWB_LR;
			c.rf_addrw = `LINK_REG;
		end
		`OPCODE_MOVHI: c.alu_op = `ALUOP_MOVHI;
		`OPCODE_ADDI: c.alu_op = `ALUOP_ADD;
		`OPCODE_ADDIC: c.alu_op = `ALUOP_ADDC;
		`OPCODE_ANDI: c.alu_op = `ALUOP_AND;
		`OPCODE_ORI: c.alu_op = `ALUOP_OR;
		`OPCODE_XORI: c.alu_op = `ALUOP_XOR;
		`OPCODE_ALU: c.alu_op = {1'b0, insn[3:0]};
		`OPCODE_MFSPR: begin
			c.rfwb_op.src = decode_pkg::RFWB_SPRS;
			c.spr_read = 1'b1;
		end
		`OPCODE_LWZ, `OPCODE_LWS, `OPCODE_LBZ, `OPCODE_LBS, `OPCODE_LHZ,
		`OPCODE_LHS:
			c.rfwb_op.src = decode_pkg::RFWB_LSU;
		// no register write
		default: c.rfwb_op = '{src: decode_pkg::RFWB_NONE, we: 1'b0};
	endcase
	if (op == `OPCODE_SFXX || op == `OPCODE_SFXXI)
		c.alu_op = `ALUOP_COMP;
	if (op == `OPCODE_MTSPR)
		c.spr_write = 1'b1;
	return c;
endfunction

function automatic logic is_illegal(input decode_pkg::insn_t insn);
	logic [4:0] func;
	logic known;
	func = insn[4:0];
	known = 1'b0;
	foreach (LEGAL_OPS[i])
		if (LEGAL_OPS[i] == insn[31:26])
			known = 1'b1;
	if (!known)
		return 1'b1;
	if (insn[31:26] != `OPCODE_ALU)
		return 1'b0;
	// mul, div, ffl1, ext and rotate have no hardware
	if (func inside {`ALUOP_MUL, `ALUOP_MULU, `ALUOP_DIV, `ALUOP_DIVU, `ALUOP_FFL1,
			`ALUOP_EXTHB, `ALUOP_EXTW})
		return 1'b1;
	return (func == `ALUOP_SHROT) && (insn[7:6] == 2'd3);
endfunction

// EX destination first, then WB, then the register file
function automatic decode_pkg::fwd_sel_e forward_sel(input decode_pkg::reg_addr_t addr,
		input logic imm);
	if (imm)
		return decode_pkg::SEL_IMM;
	if (addr == ref_ex_ctrl.rf_addrw && ref_ex_ctrl.rfwb_op.we)
		return decode_pkg::SEL_EX_FORW;
	if (addr == ref_wb_rfaddrw && wbforw_valid)
		return decode_pkg::SEL_WB_FORW;
	return decode_pkg::SEL_RF;
endfunction

// one rising edge, WB first so it sees the old EX
task automatic step_model();
	logic flush;
	logic bubble;
	flush = except_flushpipe | pc_we | extend_flush | du_flush_pipe;
	bubble = (!ex_freeze && id_freeze) || flush;
	if (reset) begin
		ref_id_insn = `NOP_INSN;
		ref_ex_insn = `NOP_INSN;
		ref_wb_insn = `NOP_INSN;
		ref_id_branch_op = decode_pkg::BR_NOP;
		ref_sel_imm = 1'b0;
		ref_ex_ctrl = IDLE_CTRL;
		ref_illegal = 1'b0;
		ref_syscall = 1'b0;
		ref_trap = 1'b0;
		ref_ex_simm = '0;
		ref_ex_target = '0;
		ref_wb_rfaddrw = '0;
	end else begin
		if (!wb_freeze) begin
			ref_wb_insn = ref_ex_insn;
			ref_wb_rfaddrw = ref_ex_ctrl.rf_addrw;
		end
		// immediate and target copies ignore the bubble
		if (!ex_freeze) begin
			ref_ex_simm = extend_imm(ref_id_insn);
			ref_ex_target = branch_target_of(ref_id_insn, id_pc);
		end
		if (bubble) begin
			ref_ex_insn = `NOP_INSN;
			ref_ex_ctrl = IDLE_CTRL;
			ref_illegal = 1'b0;
			ref_syscall = 1'b0;
			ref_trap = 1'b0;
		end else if (!ex_freeze) begin
			ref_ex_insn = ref_id_insn;
			ref_ex_ctrl = ctrl_of(ref_id_insn, ref_id_branch_op);
			ref_illegal = is_illegal(ref_id_insn);
			ref_syscall = (ref_id_insn[31:23] == {`OPCODE_XSYNC, 3'b000});
			ref_trap = (ref_id_insn[31:23] == {`OPCODE_XSYNC, 3'b010}) || du_hwbkpt;
		end
		if (flush) begin
			ref_id_insn = `NOP_INSN;
			ref_id_branch_op = decode_pkg::BR_NOP;
		end else if (!id_freeze) begin
			ref_id_insn = if_insn;
			ref_id_branch_op = branch_of(if_insn);
		end
		if (!id_freeze)
			ref_sel_imm = imm_used(if_insn);
	end
endtask

`endif

// File: test/decode_ctrl_tb.sv
`include "decode_macros.svh"

module decode_ctrl_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int STIM_CYCLES = 3000;
	// stimulus, reset and margin
	localparam int TIMEOUT_CYCLES = STIM_CYCLES + 1000;
	localparam int unsigned SEED = 32'h45f5_cafd;

	// DUT inputs
	logic clk;
	logic reset;
	logic id_freeze;
	logic ex_freeze;
	logic wb_freeze;
	logic except_flushpipe;
	logic extend_flush;
	logic pc_we;
	logic du_flush_pipe;
	logic abort_mvspr;
	decode_pkg::insn_t if_insn;
	decode_pkg::word_t id_pc;
	logic wbforw_valid;
	logic du_hwbkpt;

	// DUT outputs
	logic flushpipe;
	decode_pkg::insn_t id_insn;
	decode_pkg::insn_t ex_insn;
	decode_pkg::insn_t wb_insn;
	decode_pkg::reg_addr_t rf_addra;
	decode_pkg::reg_addr_t rf_addrb;
	logic rf_rda;
	logic rf_rdb;
	decode_pkg::branch_op_e id_branch_op;
	decode_pkg::ex_ctrl_t ex_ctrl;
	logic ex_spr_read;
	logic ex_spr_write;
	logic rfe;
	decode_pkg::fwd_sel_e sel_a;
	decode_pkg::fwd_sel_e sel_b;
	decode_pkg::word_t id_simm;
	decode_pkg::word_t ex_simm;
	decode_pkg::target_t id_branch_target;
	decode_pkg::target_t ex_branch_target;
	decode_pkg::lsu_op_t id_lsu_op;
	logic except_illegal;
	logic sig_syscall;
	logic sig_trap;

	int cycles;

	`include "decode_model.svh"

	decode_ctrl i_decode_ctrl (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// model steps on every edge, inputs settled 2 ns after the last one
	always @(posedge clk)
		step_model();

	////////////////////////////////////////////////////////////
	// failure and compare tasks
	////////////////////////////////////////////////////////////

	task automatic stop_run();
		$display("TEST FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic insn_cmp(input string name, input decode_pkg::insn_t got,
			input decode_pkg::insn_t want);
		if (got !== want) begin
			$display("error %s got %h expected %h", name, got, want);
			stop_run();
		end
	endtask

	task automatic ctrl_cmp(input string name, input decode_pkg::ex_ctrl_t got,
			input decode_pkg::ex_ctrl_t want);
		if (got !== want) begin
			$display("error %s got %h expected %h", name, got, want);
			stop_run();
		end
	endtask

	task automatic word_cmp(input string name, input decode_pkg::word_t got,
			input decode_pkg::word_t want);
		if (got !== want) begin
			$display("error %s got %h expected %h", name, got, want);
			stop_run();
		end
	endtask

	task automatic target_cmp(input string name, input decode_pkg::target_t got,
			input decode_pkg::target_t want);
		if (got !== want) begin
			$display("error %s got %h expected %h", name, got, want);
			stop_run();
		end
	endtask

	task automatic lsu_cmp(input string name, input decode_pkg::lsu_op_t got,
			input decode_pkg::lsu_op_t want);
		if (got !== want) begin
			$display("error %s got %h expected %h", name, got, want);
			stop_run();
		end
	endtask

	task automatic branch_cmp(input string name, input decode_pkg::branch_op_e got,
			input decode_pkg::branch_op_e want);
		if (got !== want) begin
			$display("error %s got %h expected %h", name, got, want);
			stop_run();
		end
	endtask

	task automatic sel_cmp(input string name, input decode_pkg::fwd_sel_e got,
			input decode_pkg::fwd_sel_e want);
		if (got !== want) begin
			$display("error %s got %h expected %h", name, got, want);
			stop_run();
		end
	endtask

	task automatic addr_cmp(input string name, input decode_pkg::reg_addr_t got,
			input decode_pkg::reg_addr_t want);
		if (got !== want) begin
			$display("error %s got %h expected %h", name, got, want);
			stop_run();
		end
	endtask

	task automatic flag_cmp(input string name, input logic got, input logic want);
		if (got !== want) begin
			$display("error %s got %h expected %h", name, got, want);
			stop_run();
		end
	endtask

	////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////

	// mostly legal opcodes, extra alu words, some random junk
	function automatic decode_pkg::insn_t random_insn();
		decode_pkg::insn_t insn;
		int unsigned pick;
		insn = $urandom();
		pick = $urandom_range(0, 99);
		if (pick < 70)
			insn[31:26] = LEGAL_OPS[$urandom_range(0, 28)];
		else if (pick < 85)
			insn[31:26] = `OPCODE_ALU;
		// few registers so forwarding hits often
		if ($urandom_range(0, 1) == 1) begin
			insn[25:21] = 5'($urandom_range(0, 3));
			insn[20:16] = 5'($urandom_range(0, 3));
			insn[15:11] = 5'($urandom_range(0, 3));
		end
		// sys, trap and neighbours
		if (insn[31:26] == `OPCODE_XSYNC)
			insn[25:23] = 3'($urandom_range(0, 3));
		return insn;
	endfunction

	task automatic drive_random();
		if_insn = random_insn();
		id_pc = $urandom();
		id_freeze = ($urandom_range(0, 99) < 10);
		ex_freeze = ($urandom_range(0, 99) < 8);
		wb_freeze = ($urandom_range(0, 99) < 8);
		except_flushpipe = ($urandom_range(0, 99) < 2);
		extend_flush = ($urandom_range(0, 99) < 2);
		pc_we = ($urandom_range(0, 99) < 2);
		du_flush_pipe = ($urandom_range(0, 99) < 2);
		abort_mvspr = ($urandom_range(0, 99) < 20);
		wbforw_valid = ($urandom_range(0, 1) == 1);
		du_hwbkpt = ($urandom_range(0, 99) < 3);
	endtask

	// sampled mid cycle, registers and comb paths settled
	task automatic check_outputs();
		logic flush;
		logic rfe_want;
		flush = except_flushpipe | pc_we | extend_flush | du_flush_pipe;
		rfe_want = (ref_id_branch_op == decode_pkg::BR_RFE) ||
			(ref_ex_ctrl.branch_op == decode_pkg::BR_RFE);
		insn_cmp("id_insn", id_insn, ref_id_insn);
		insn_cmp("ex_insn", ex_insn, ref_ex_insn);
		insn_cmp("wb_insn", wb_insn, ref_wb_insn);
		flag_cmp("flushpipe", flushpipe, flush);
		// register file read port straight from the fetched word
		addr_cmp("rf_addra", rf_addra, if_insn[20:16]);
		addr_cmp("rf_addrb", rf_addrb, if_insn[15:11]);
		flag_cmp("rf_rda", rf_rda, if_insn[31]);
		flag_cmp("rf_rdb", rf_rdb, if_insn[30]);
		branch_cmp("id_branch_op", id_branch_op, ref_id_branch_op);
		word_cmp("id_simm", id_simm, extend_imm(ref_id_insn));
		word_cmp("ex_simm", ex_simm, ref_ex_simm);
		target_cmp("id_branch_target", id_branch_target, branch_target_of(ref_id_insn, id_pc));
		target_cmp("ex_branch_target", ex_branch_target, ref_ex_target);
		lsu_cmp("id_lsu_op", id_lsu_op, lsu_op_of(ref_id_insn));
		ctrl_cmp("ex_ctrl", ex_ctrl, ref_ex_ctrl);
		flag_cmp("ex_spr_read", ex_spr_read, ref_ex_ctrl.spr_read && !abort_mvspr);
		flag_cmp("ex_spr_write", ex_spr_write, ref_ex_ctrl.spr_write && !abort_mvspr);
		flag_cmp("rfe", rfe, rfe_want);
		flag_cmp("except_illegal", except_illegal, ref_illegal);
		flag_cmp("sig_syscall", sig_syscall, ref_syscall);
		flag_cmp("sig_trap", sig_trap, ref_trap);
		sel_cmp("sel_a", sel_a, forward_sel(ref_id_insn[20:16], 1'b0));
		sel_cmp("sel_b", sel_b, forward_sel(ref_id_insn[15:11], ref_sel_imm));
	endtask

	////////////////////////////////////////////////////////////
	// run control
	////////////////////////////////////////////////////////////

	initial begin
		cycles = 0;
		forever begin
			@(posedge clk);
			cycles++;
			if (cycles >= TIMEOUT_CYCLES) begin
				$display("timeout, the run did not end within %0d cycles", TIMEOUT_CYCLES);
				stop_run();
			end
		end
	end

	initial begin
		void'($urandom(SEED));
		reset = 1'b1;
		id_freeze = 1'b0;
		ex_freeze = 1'b0;
		wb_freeze = 1'b0;
		except_flushpipe = 1'b0;
		extend_flush = 1'b0;
		pc_we = 1'b0;
		du_flush_pipe = 1'b0;
		abort_mvspr = 1'b0;
		if_insn = `NOP_INSN;
		id_pc = '0;
		wbforw_valid = 1'b0;
		du_hwbkpt = 1'b0;
		repeat (3) @(posedge clk);
		#2;
		reset = 1'b0;
		drive_random();
		for (int i = 0; i < STIM_CYCLES; i++) begin
			@(negedge clk);
			check_outputs();
			@(posedge clk);
			#2;
			drive_random();
		end
		$display("TEST PASS");
		$finish;
	end

endmodule
